// File: design/cpu_config.svh
/* cpu configuration
   datapath widths, register count and boot address of the core */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_XLEN        32              // data and address width
`define CPU_REG_ADDR_W  5
`define CPU_NUM_REGS    32

// boot rom base of the test environment
`define CPU_RESET_PC    32'hbfc00000

`endif

// File: design/cpu_isa_pkg.sv
/* isa package
   instruction word layout, opcode and funct codes, alu operations */
`default_nettype none

package cpu_isa_pkg;

    // one instruction word, seen as r- or i-format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_u;

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    localparam logic [3:0] ALU_ADD = 4'd0;
    localparam logic [3:0] ALU_SUB = 4'd1;
    localparam logic [3:0] ALU_AND = 4'd2;
    localparam logic [3:0] ALU_OR  = 4'd3;
    localparam logic [3:0] ALU_XOR = 4'd4;
    localparam logic [3:0] ALU_SLT = 4'd5;
    localparam logic [3:0] ALU_LUI = 4'd6;

endpackage

`default_nettype wire

// File: design/cpu_pipe_pkg.sv
/* pipeline package
   trace byte enables and the sequential pc step */
`default_nettype none

`include "cpu_config.svh"

package cpu_pipe_pkg;

    // debug_wb_rf_wen codes
    localparam logic [3:0] TRACE_WEN_ON  = 4'b1111;
    localparam logic [3:0] TRACE_WEN_OFF = 4'b0000;

    // one instruction word per fetch
    localparam logic [`CPU_XLEN-1:0] PC_STEP = `CPU_XLEN'd4;

endpackage

`default_nettype wire

// File: design/fetch_stage.sv
/* fetch stage
   program counter and the fetch-to-decode register */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module fetch_stage (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 stage_wr,
    input  logic                 fetch_bubble,
    input  logic [`CPU_XLEN-1:0] inst,
    output logic [`CPU_XLEN-1:0] inst_addr,
    output logic                 id_valid,
    output logic [`CPU_XLEN-1:0] id_pc,
    output logic [`CPU_XLEN-1:0] id_inst
);
    import cpu_pipe_pkg::*;

    logic [`CPU_XLEN-1:0] pc;

    assign inst_addr = pc;

    always_ff @(posedge aclk) begin
        if (rst) begin
            pc       <= `CPU_RESET_PC;
            id_valid <= 1'b0;
        end else if (stage_wr) begin
            id_valid <= !fetch_bubble;    // no word this cycle, send a bubble
            if (!fetch_bubble) begin
                pc <= pc + PC_STEP;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (stage_wr && !fetch_bubble) begin
            id_pc   <= pc;
            id_inst <= inst;
        end
    end

    a_pc_aligned: assert property (@(posedge aclk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: design/decode_stage.sv
/* decode stage
   register file, instruction decode and the decode-to-execute register */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module decode_stage (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       stage_wr,
    input  logic                       id_valid,
    input  logic [`CPU_XLEN-1:0]       id_pc,
    input  logic [`CPU_XLEN-1:0]       id_inst,
    input  logic                       rf_we,
    input  logic [`CPU_REG_ADDR_W-1:0] rf_waddr,
    input  logic [`CPU_XLEN-1:0]       rf_wdata,
    output logic                       ex_valid,
    output logic [`CPU_XLEN-1:0]       ex_pc,
    output logic [3:0]                 ex_alu_op,
    output logic [`CPU_REG_ADDR_W-1:0] ex_rs,
    output logic [`CPU_REG_ADDR_W-1:0] ex_rt,
    output logic [`CPU_XLEN-1:0]       ex_opa,
    output logic [`CPU_XLEN-1:0]       ex_opb,
    output logic [`CPU_XLEN-1:0]       ex_imm,
    output logic                       ex_use_imm,
    output logic [`CPU_REG_ADDR_W-1:0] ex_dst,
    output logic                       ex_wr
);
    import cpu_isa_pkg::*;

    logic [`CPU_XLEN-1:0]       rf [`CPU_NUM_REGS];
    instr_u                     ir;
    logic [3:0]                 alu_op;
    logic                       use_imm;
    logic                       zero_ext;
    logic                       known;
    logic [`CPU_REG_ADDR_W-1:0] dst;
    logic [`CPU_XLEN-1:0]       imm;
    logic [`CPU_XLEN-1:0]       rs_data;
    logic [`CPU_XLEN-1:0]       rt_data;

    // write-through read, r0 is hardwired zero
    function automatic logic [`CPU_XLEN-1:0] rf_read(input logic [`CPU_REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (rf_we && rf_waddr == addr) begin
            return rf_wdata;
        end
        return rf[addr];
    endfunction

    always_ff @(posedge aclk) begin
        if (rf_we && rf_waddr != '0) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    always_comb begin
        rs_data = rf_read(ir.r.rs);
        rt_data = rf_read(ir.r.rt);
    end

    assign ir = id_inst;

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b1;
        known   = 1'b1;
        case (ir.r.opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                case (ir.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            default:  known = 1'b0;     // committed as a no-op
        endcase
    end

    // logical immediates are zero extended
    assign zero_ext = ir.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI};
    assign imm = zero_ext ? {{(`CPU_XLEN-16){1'b0}}, ir.i.imm}
                          : {{(`CPU_XLEN-16){ir.i.imm[15]}}, ir.i.imm};
    assign dst = use_imm ? ir.i.rt : ir.r.rd;

    always_ff @(posedge aclk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
        end else if (stage_wr) begin
            ex_valid <= id_valid;
            ex_wr    <= id_valid && known && dst != '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (stage_wr) begin
            ex_pc      <= id_pc;
            ex_alu_op  <= alu_op;
            ex_rs      <= ir.r.rs;
            ex_rt      <= ir.r.rt;
            ex_opa     <= rs_data;
            ex_opb     <= rt_data;
            ex_imm     <= imm;
            ex_use_imm <= use_imm;
            ex_dst     <= dst;
        end else begin
            // frozen entry picks up the commit made during the stall
            if (rf_we && rf_waddr == ex_rs) begin
                ex_opa <= rf_wdata;
            end
            if (rf_we && rf_waddr == ex_rt) begin
                ex_opb <= rf_wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
/* execute stage
   operand forwarding, alu and the execute-to-writeback register */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module execute_stage (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       stage_wr,
    input  logic                       ex_valid,
    input  logic [`CPU_XLEN-1:0]       ex_pc,
    input  logic [3:0]                 ex_alu_op,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_rs,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_rt,
    input  logic [`CPU_XLEN-1:0]       ex_opa,
    input  logic [`CPU_XLEN-1:0]       ex_opb,
    input  logic [`CPU_XLEN-1:0]       ex_imm,
    input  logic                       ex_use_imm,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_dst,
    input  logic                       ex_wr,
    input  logic                       fwd_we,
    input  logic [`CPU_REG_ADDR_W-1:0] fwd_dst,
    input  logic [`CPU_XLEN-1:0]       fwd_data,
    output logic                       wb_valid,
    output logic [`CPU_XLEN-1:0]       wb_pc,
    output logic                       wb_wr,
    output logic [`CPU_REG_ADDR_W-1:0] wb_dst,
    output logic [`CPU_XLEN-1:0]       wb_result
);
    import cpu_isa_pkg::*;

    logic [`CPU_XLEN-1:0] opa;
    logic [`CPU_XLEN-1:0] opb;
    logic [`CPU_XLEN-1:0] alu_b;
    logic [`CPU_XLEN-1:0] result;

    // youngest producer wins, own output register before writeback
    function automatic logic [`CPU_XLEN-1:0] fwd(input logic [`CPU_REG_ADDR_W-1:0] src,
                                                  input logic [`CPU_XLEN-1:0] value);
        if (wb_wr && wb_dst == src) begin
            return wb_result;
        end
        if (fwd_we && fwd_dst == src) begin
            return fwd_data;
        end
        return value;
    endfunction

    always_comb begin
        opa = fwd(ex_rs, ex_opa);
        opb = fwd(ex_rt, ex_opb);
    end

    assign alu_b = ex_use_imm ? ex_imm : opb;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: result = opa + alu_b;
            ALU_SUB: result = opa - alu_b;
            ALU_AND: result = opa & alu_b;
            ALU_OR:  result = opa | alu_b;
            ALU_XOR: result = opa ^ alu_b;
            ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, $signed(opa) < $signed(alu_b)};
            ALU_LUI: result = {alu_b[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_wr    <= 1'b0;
        end else if (stage_wr) begin
            wb_valid <= ex_valid;
            wb_wr    <= ex_wr;      // already qualified by valid in decode
        end
    end

    always_ff @(posedge aclk) begin
        if (stage_wr) begin
            wb_pc     <= ex_pc;
            wb_dst    <= ex_dst;
            wb_result <= result;
        end
    end

endmodule

`default_nettype wire

// File: design/writeback_stage.sv
/* writeback stage
   commits the held entry once to the register file and the trace ports */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module writeback_stage (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       stage_wr,
    input  logic                       wb_dis_wr,
    input  logic                       wb_valid,
    input  logic [`CPU_XLEN-1:0]       wb_pc,
    input  logic                       wb_wr,
    input  logic [`CPU_REG_ADDR_W-1:0] wb_dst,
    input  logic [`CPU_XLEN-1:0]       wb_result,
    output logic                       rf_we,
    output logic [`CPU_REG_ADDR_W-1:0] rf_waddr,
    output logic [`CPU_XLEN-1:0]       rf_wdata,
    output logic [`CPU_XLEN-1:0]       debug_wb_pc,
    output logic [`CPU_XLEN-1:0]       debug_wb_rf_wdata,
    output logic [3:0]                 debug_wb_rf_wen,
    output logic [`CPU_REG_ADDR_W-1:0] debug_wb_rf_wnum
);
    import cpu_pipe_pkg::*;

    logic                       valid_q;
    logic                       wr_q;
    logic [`CPU_XLEN-1:0]       pc_q;
    logic [`CPU_REG_ADDR_W-1:0] dst_q;
    logic [`CPU_XLEN-1:0]       result_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;
            wr_q    <= 1'b0;
        end else if (stage_wr) begin
            valid_q <= wb_valid;
            wr_q    <= wb_wr;
        end
    end

    always_ff @(posedge aclk) begin
        if (stage_wr) begin
            pc_q     <= wb_pc;
            dst_q    <= wb_dst;
            result_q <= wb_result;
        end
    end

    // held entry is masked after its first cycle
    assign rf_we    = valid_q && wr_q && !wb_dis_wr;
    assign rf_waddr = dst_q;
    assign rf_wdata = result_q;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_wdata = result_q;
    assign debug_wb_rf_wen   = rf_we ? TRACE_WEN_ON : TRACE_WEN_OFF;
    assign debug_wb_rf_wnum  = dst_q;

    // a frozen entry never commits twice in a row
    a_single_commit: assert property (@(posedge aclk) disable iff (rst)
        rf_we && !stage_wr |=> !rf_we);

endmodule

`default_nettype wire

// File: design/pipeline_control.sv
/* pipeline control
   stage write enable, fetch bubble and writeback commit mask */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module pipeline_control (
    input  logic aclk,
    input  logic rst,
    input  logic inst_valid,
    input  logic ibus_busy,
    output logic stage_wr,
    output logic fetch_bubble,
    output logic wb_dis_wr
);

    assign stage_wr     = !ibus_busy;   // busy freezes every stage and the pc
    assign fetch_bubble = !inst_valid;

    // writeback entry was held last cycle, so it already committed
    always_ff @(posedge aclk) begin
        if (rst) begin
            wb_dis_wr <= 1'b0;
        end else begin
            wb_dis_wr <= !stage_wr;
        end
    end

    a_dis_after_freeze: assert property (@(posedge aclk) disable iff (rst)
        stage_wr |=> !wb_dis_wr);

endmodule

`default_nettype wire

// File: design/mycpu_top.sv
/* cpu top level
   four stage integer core with a plain instruction port and trace outputs */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module mycpu_top (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       inst_valid,
    input  logic                       ibus_busy,
    input  logic [`CPU_XLEN-1:0]       inst,
    output logic [`CPU_XLEN-1:0]       inst_addr,
    output logic [`CPU_XLEN-1:0]       debug_wb_pc,
    output logic [`CPU_XLEN-1:0]       debug_wb_rf_wdata,
    output logic [3:0]                 debug_wb_rf_wen,
    output logic [`CPU_REG_ADDR_W-1:0] debug_wb_rf_wnum
);
    logic                       stage_wr;
    logic                       fetch_bubble;
    logic                       wb_dis_wr;
    logic                       id_valid;
    logic [`CPU_XLEN-1:0]       id_pc;
    logic [`CPU_XLEN-1:0]       id_inst;
    logic                       ex_valid;
    logic [`CPU_XLEN-1:0]       ex_pc;
    logic [3:0]                 ex_alu_op;
    logic [`CPU_REG_ADDR_W-1:0] ex_rs;
    logic [`CPU_REG_ADDR_W-1:0] ex_rt;
    logic [`CPU_XLEN-1:0]       ex_opa;
    logic [`CPU_XLEN-1:0]       ex_opb;
    logic [`CPU_XLEN-1:0]       ex_imm;
    logic                       ex_use_imm;
    logic [`CPU_REG_ADDR_W-1:0] ex_dst;
    logic                       ex_wr;
    logic                       wb_valid;
    logic [`CPU_XLEN-1:0]       wb_pc;
    logic                       wb_wr;
    logic [`CPU_REG_ADDR_W-1:0] wb_dst;
    logic [`CPU_XLEN-1:0]       wb_result;
    logic                       rf_we;      // committed write, also the forward source
    logic [`CPU_REG_ADDR_W-1:0] rf_waddr;
    logic [`CPU_XLEN-1:0]       rf_wdata;

    pipeline_control u_control (.aclk, .rst, .inst_valid, .ibus_busy,
        .stage_wr, .fetch_bubble, .wb_dis_wr);

    fetch_stage u_fetch (.aclk, .rst, .stage_wr, .fetch_bubble, .inst,
        .inst_addr, .id_valid, .id_pc, .id_inst);

    decode_stage u_decode (.aclk, .rst, .stage_wr, .id_valid, .id_pc, .id_inst,
        .rf_we, .rf_waddr, .rf_wdata, .ex_valid, .ex_pc, .ex_alu_op, .ex_rs, .ex_rt,
        .ex_opa, .ex_opb, .ex_imm, .ex_use_imm, .ex_dst, .ex_wr);

    execute_stage u_execute (.aclk, .rst, .stage_wr, .ex_valid, .ex_pc, .ex_alu_op,
        .ex_rs, .ex_rt, .ex_opa, .ex_opb, .ex_imm, .ex_use_imm, .ex_dst, .ex_wr,
        .fwd_we(rf_we), .fwd_dst(rf_waddr), .fwd_data(rf_wdata),
        .wb_valid, .wb_pc, .wb_wr, .wb_dst, .wb_result);

    writeback_stage u_writeback (.aclk, .rst, .stage_wr, .wb_dis_wr, .wb_valid, .wb_pc,
        .wb_wr, .wb_dst, .wb_result, .rf_we, .rf_waddr, .rf_wdata, .debug_wb_pc,
        .debug_wb_rf_wdata, .debug_wb_rf_wen, .debug_wb_rf_wnum);

endmodule

`default_nettype wire

// File: test/tb_mycpu_top.sv
/* testbench for the four stage core
   drives programs from a memory model and checks the trace against an isa model */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module tb_mycpu_top;
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam int PERIOD      = 8;
    localparam int MEM_WORDS   = 256;
    localparam int PROG_TOTAL  = 76;                    // instructions over all tests
    localparam int CYCLE_LIMIT = PROG_TOTAL * 8 + 200;

    logic                       aclk = 1'b0;
    logic                       rst;
    logic                       inst_valid;
    logic                       ibus_busy;
    logic [`CPU_XLEN-1:0]       inst;
    logic [`CPU_XLEN-1:0]       inst_addr;
    logic [`CPU_XLEN-1:0]       debug_wb_pc;
    logic [`CPU_XLEN-1:0]       debug_wb_rf_wdata;
    logic [3:0]                 debug_wb_rf_wen;
    logic [`CPU_REG_ADDR_W-1:0] debug_wb_rf_wnum;

    logic [`CPU_XLEN-1:0]       mem [MEM_WORDS];
    logic [`CPU_XLEN-1:0]       model_rf [`CPU_NUM_REGS];
    logic [`CPU_XLEN-1:0]       word_off;
    logic [31:0]                rng_state = 32'hbb19;
    int                         load_idx = 0;
    int                         cycles = 0;
    time                        first_accept;

    logic [`CPU_XLEN-1:0]       exp_pc_q[$];
    logic [`CPU_REG_ADDR_W-1:0] exp_num_q[$];
    logic [`CPU_XLEN-1:0]       exp_data_q[$];
    logic [`CPU_XLEN-1:0]       tr_pc[$];
    logic [`CPU_REG_ADDR_W-1:0] tr_num[$];
    logic [`CPU_XLEN-1:0]       tr_data[$];
    logic [3:0]                 tr_wen[$];
    time                        tr_time[$];

    mycpu_top mycpu_top_inst (.aclk, .rst, .inst_valid, .ibus_busy, .inst, .inst_addr,
        .debug_wb_pc, .debug_wb_rf_wdata, .debug_wb_rf_wen, .debug_wb_rf_wnum);

    always #(PERIOD / 2) aclk = ~aclk;

    assign word_off = inst_addr - `CPU_RESET_PC;
    assign inst     = mem[word_off[9:2]];      // same cycle answer

    task abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task check_word(input logic [`CPU_XLEN-1:0] got, input logic [`CPU_XLEN-1:0] exp,
                    input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task check_reg(input logic [`CPU_REG_ADDR_W-1:0] got,
                   input logic [`CPU_REG_ADDR_W-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task check_wen(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run($sformatf("run stopped after %0d cycles, the tests did not finish",
                                CYCLE_LIMIT));
        end
    end

    // one entry per committing cycle
    always @(negedge aclk) begin
        if (!rst && debug_wb_rf_wen !== TRACE_WEN_OFF) begin
            tr_pc.push_back(debug_wb_pc);
            tr_num.push_back(debug_wb_rf_wnum);
            tr_data.push_back(debug_wb_rf_wdata);
            tr_wen.push_back(debug_wb_rf_wen);
            tr_time.push_back($time);
        end
    end

    function automatic logic [31:0] rand_next();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [15:0] rand_imm();
        return 16'(rand_next());
    endfunction

    // sources and targets stay in r1..r20, all written by the first programs
    function automatic logic [4:0] random_reg();
        return 5'(rand_next() % 20 + 1);
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_instr(input logic [4:0] rs, input logic [4:0] dst);
        logic [4:0] rt;
        rt = random_reg();
        case (rand_next() % 11)
            0: return r_word(FN_ADDU, dst, rs, rt);
            1: return r_word(FN_SUBU, dst, rs, rt);
            2: return r_word(FN_AND, dst, rs, rt);
            3: return r_word(FN_OR, dst, rs, rt);
            4: return r_word(FN_XOR, dst, rs, rt);
            5: return r_word(FN_SLT, dst, rs, rt);
            6: return i_word(OP_ADDIU, dst, rs, rand_imm());
            7: return i_word(OP_ANDI, dst, rs, rand_imm());
            8: return i_word(OP_ORI, dst, rs, rand_imm());
            9: return i_word(OP_XORI, dst, rs, rand_imm());
            default: return i_word(OP_LUI, dst, 5'd0, rand_imm());
        endcase
    endfunction

    // in-order isa model, queues the trace entry of every register write
    task automatic model_exec(input logic [31:0] pc, input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        ok;
        a   = model_rf[w[25:21]];
        b   = model_rf[w[20:16]];
        dst = w[20:16];
        ok  = 1'b1;
        res = '0;
        case (w[31:26])
            OP_SPECIAL: begin
                dst = w[15:11];
                case (w[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ok = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + {{16{w[15]}}, w[15:0]};
            OP_ANDI:  res = a & {16'd0, w[15:0]};
            OP_ORI:   res = a | {16'd0, w[15:0]};
            OP_XORI:  res = a ^ {16'd0, w[15:0]};
            OP_LUI:   res = {w[15:0], 16'd0};
            default:  ok = 1'b0;
        endcase
        if (ok && dst != 5'd0) begin
            model_rf[dst] = res;
            exp_pc_q.push_back(pc);
            exp_num_q.push_back(dst);
            exp_data_q.push_back(res);
        end
    endtask

    task automatic emit(input logic [31:0] w);
        mem[load_idx] = w;
        model_exec(`CPU_RESET_PC + 32'(load_idx * 4), w);
        load_idx++;
    endtask

    task automatic clear_trace();
        exp_pc_q.delete();
        exp_num_q.delete();
        exp_data_q.delete();
        tr_pc.delete();
        tr_num.delete();
        tr_data.delete();
        tr_wen.delete();
        tr_time.delete();
    endtask

    // hands n words to the core, pc must hold on every cycle that accepts nothing
    task automatic feed(input int n, input int gap_pct, input int busy_pct);
        int                   accepted;
        logic                 gap;
        logic                 busy;
        logic [`CPU_XLEN-1:0] fetch_pc;
        accepted = 0;
        fetch_pc = `CPU_RESET_PC + 32'(load_idx * 4 - n * 4);
        while (accepted < n) begin
            gap  = (rand_next() % 100) < gap_pct;
            busy = (rand_next() % 100) < busy_pct;
            inst_valid <= !gap;
            ibus_busy  <= busy;
            @(negedge aclk);
            check_word(inst_addr, fetch_pc, "inst_addr");
            @(posedge aclk);
            if (inst_valid && !ibus_busy) begin
                if (accepted == 0) begin
                    first_accept = $time;
                end
                accepted++;
                fetch_pc += 32'd4;
            end
        end
        inst_valid <= 1'b0;
        ibus_busy  <= 1'b0;
    endtask

    task automatic compare_trace();
        int i;
        while (tr_num.size() < exp_num_q.size()) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);     // a duplicate would surface within the pipe depth
        if (tr_num.size() != exp_num_q.size()) begin
            abort_run($sformatf("trace holds %0d entries where %0d were expected",
                                tr_num.size(), exp_num_q.size()));
        end
        for (i = 0; i < exp_num_q.size(); i++) begin
            check_wen(tr_wen[i], TRACE_WEN_ON, "trace byte enables");
            check_word(tr_pc[i], exp_pc_q[i], "trace pc");
            check_reg(tr_num[i], exp_num_q[i], "trace register");
            check_word(tr_data[i], exp_data_q[i], "trace data");
        end
    endtask

    task automatic test_reset_state();
        int i;
        for (i = 0; i < 6; i++) begin
            @(negedge aclk);
            check_word(inst_addr, `CPU_RESET_PC, "inst_addr after reset");
            @(posedge aclk);
        end
        if (tr_num.size() != 0) begin
            abort_run("a trace entry appeared while no instruction was fetched");
        end
    endtask

    task automatic test_independent();
        time lat;
        clear_trace();
        emit(i_word(OP_LUI, 5'd1, 5'd0, rand_imm()));
        emit(i_word(OP_ORI, 5'd2, 5'd0, rand_imm()));
        emit(i_word(OP_ADDIU, 5'd3, 5'd0, rand_imm()));
        emit(i_word(OP_XORI, 5'd4, 5'd0, rand_imm()));
        emit(i_word(OP_ANDI, 5'd5, 5'd0, rand_imm()));
        emit(i_word(OP_ADDIU, 5'd6, 5'd0, rand_imm()));
        emit(r_word(FN_ADDU, 5'd7, 5'd1, 5'd2));
        emit(r_word(FN_SUBU, 5'd8, 5'd3, 5'd4));
        emit(r_word(FN_AND, 5'd9, 5'd1, 5'd3));
        emit(r_word(FN_OR, 5'd10, 5'd2, 5'd4));
        emit(r_word(FN_XOR, 5'd11, 5'd5, 5'd6));
        emit(r_word(FN_SLT, 5'd12, 5'd3, 5'd4));
        feed(12, 0, 0);
        compare_trace();
        lat = (tr_time[0] - first_accept - PERIOD / 2) / PERIOD;
        check_word(32'(lat), 32'd3, "cycles from fetch to first trace entry");
    endtask

    // sources at distance one and two, and three for the write-through read
    task automatic test_dependent_chains();
        clear_trace();
        emit(i_word(OP_ADDIU, 5'd13, 5'd1, rand_imm()));
        emit(r_word(FN_ADDU, 5'd13, 5'd13, 5'd2));
        emit(r_word(FN_SUBU, 5'd14, 5'd13, 5'd3));
        emit(r_word(FN_XOR, 5'd15, 5'd13, 5'd14));
        emit(i_word(OP_ORI, 5'd13, 5'd15, rand_imm()));
        emit(r_word(FN_AND, 5'd16, 5'd14, 5'd15));
        emit(r_word(FN_SLT, 5'd17, 5'd16, 5'd13));
        emit(i_word(OP_ADDIU, 5'd17, 5'd17, rand_imm()));
        emit(i_word(OP_XORI, 5'd18, 5'd16, rand_imm()));
        emit(r_word(FN_ADDU, 5'd18, 5'd18, 5'd17));
        emit(i_word(OP_LUI, 5'd19, 5'd0, rand_imm()));
        emit(r_word(FN_OR, 5'd19, 5'd19, 5'd18));
        emit(r_word(FN_SUBU, 5'd20, 5'd19, 5'd17));
        emit(r_word(FN_SLT, 5'd20, 5'd20, 5'd19));
        emit(r_word(FN_ADDU, 5'd16, 5'd20, 5'd16));
        emit(r_word(FN_XOR, 5'd13, 5'd16, 5'd20));
        feed(16, 0, 0);
        compare_trace();
    endtask

    task automatic test_valid_gaps();
        int i;
        clear_trace();
        for (i = 0; i < 20; i++) begin
            emit(random_instr(random_reg(), random_reg()));
        end
        feed(20, 40, 0);
        compare_trace();
    endtask

    task automatic test_busy_stalls();
        int         i;
        logic [4:0] prev;
        logic [4:0] dst;
        clear_trace();
        prev = random_reg();
        for (i = 0; i < 20; i++) begin
            dst = random_reg();
            emit(random_instr(prev, dst));  // each reads the one before
            prev = dst;
        end
        feed(20, 10, 35);
        compare_trace();
    endtask

    task automatic test_reg_zero_and_unsupported();
        clear_trace();
        emit({6'b100011, 5'd1, 5'd6, 16'h0010});    // load word, outside the core
        emit(r_word(6'h00, 5'd6, 5'd1, 5'd2));      // shift funct
        emit(i_word(OP_ADDIU, 5'd0, 5'd1, rand_imm()));
        emit(r_word(FN_ADDU, 5'd0, 5'd2, 5'd3));
        emit(r_word(FN_OR, 5'd21, 5'd0, 5'd0));
        emit(r_word(FN_ADDU, 5'd22, 5'd0, 5'd1));
        emit(i_word(OP_ORI, 5'd23, 5'd0, rand_imm()));
        emit(r_word(FN_ADDU, 5'd24, 5'd6, 5'd0));
        feed(8, 0, 0);
        compare_trace();
        check_word(tr_data[0], '0, "read of register 0");
    endtask

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        ibus_busy  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {6'h3f, 26'(i)};   // unused words decode as no-ops
        end
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            model_rf[i] = '0;
        end
        repeat (2) @(posedge aclk);
        rst <= 1'b0;
        test_reset_state();
        test_independent();
        test_dependent_chains();
        test_valid_gaps();
        test_busy_stalls();
        test_reg_zero_and_unsupported();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: mycpu_top.f
+incdir+design
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/pipeline_control.sv
design/mycpu_top.sv
test/tb_mycpu_top.sv

// File: Bender.yml
package:
  name: mycpu

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_isa_pkg.sv
      - design/cpu_pipe_pkg.sv
      - design/fetch_stage.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/writeback_stage.sv
      - design/pipeline_control.sv
      - design/mycpu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_mycpu_top.sv
